// File: source/bru_dq_config.svh
// branch dispatch queue sizing and register width constants
`ifndef BRU_DQ_CONFIG_SVH
`define BRU_DQ_CONFIG_SVH

// ----------------------------------------------------------------------
// queue geometry
`define BRU_DQ_ENTRIES 4
`define BRU_DQ_WAYS 4

// ----------------------------------------------------------------------
// register, rob and op widths
`define LOG_PR_COUNT 6
`define LOG_ROB_ENTRIES 7
`define BRU_OP_WIDTH 4

// bank select comes from the low bits of a register index
`define LOG_PRF_BANK_COUNT 2
`define PRF_BANK_COUNT (1 << `LOG_PRF_BANK_COUNT)

`endif

// File: source/bru_dq_pkg.sv
// branch dispatch queue op, operand, slot and writeback bus types
`default_nettype none

`include "bru_dq_config.svh"

package bru_dq_pkg;

    // one source operand
    typedef struct packed {
        logic [`LOG_PR_COUNT-1:0] pr;
        logic                     ready;
        logic                     unneeded_or_is_zero;
    } bru_src_t;

    // fixed payload of one op
    typedef struct packed {
        logic [`BRU_OP_WIDTH-1:0]    op;
        logic [31:0]                 pc;
        logic [19:0]                 imm20;
        logic [`LOG_PR_COUNT-1:0]    dest_pr;
        logic [`LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_op_t;

    // everything one queue entry stores
    typedef struct packed {
        bru_op_t  op;
        bru_src_t a;
        bru_src_t b;
    } bru_slot_t;

    // what an entry may load on the next edge
    typedef struct packed {
        logic      valid;
        bru_slot_t slot;
    } bru_fill_t;

    // one writeback bank, index without its bank bits
    typedef struct packed {
        logic                                          valid;
        logic [`LOG_PR_COUNT-`LOG_PRF_BANK_COUNT-1:0] upper_pr;
    } wb_bank_t;

endpackage

`default_nettype wire

// File: source/bru_dq_alloc.sv
// dispatch allocator, picks free entries in way order and routes ops to them
`default_nettype none
`timescale 1ns/1ps

`include "bru_dq_config.svh"

module bru_dq_alloc (
    input  logic [`BRU_DQ_WAYS-1:0]                      dispatch_attempt,
    input  logic [`BRU_DQ_WAYS-1:0]                      dispatch_valid,
    input  bru_dq_pkg::bru_slot_t [`BRU_DQ_WAYS-1:0]     dispatch_slot,
    input  logic [`BRU_DQ_ENTRIES-1:0]                   entry_valid,
    output logic [`BRU_DQ_WAYS-1:0]                      dispatch_ack,
    output bru_dq_pkg::bru_fill_t [`BRU_DQ_ENTRIES-1:0]  fill_by_entry
);

    // one-hot target entry per way, zero when the way gets nothing
    logic [`BRU_DQ_WAYS-1:0][`BRU_DQ_ENTRIES-1:0] grant_by_way;

    // ----------------------------------------------------------------------
    // priority chain

    always_comb begin
        logic [`BRU_DQ_ENTRIES-1:0] open_mask;
        logic [`BRU_DQ_ENTRIES-1:0] lowest_open;

        // only current valid bits count, a launch this cycle frees nothing
        open_mask = ~entry_valid;
        for (int way = 0; way < `BRU_DQ_WAYS; way++) begin
            // isolate lowest free entry
            lowest_open = open_mask & (-open_mask);

            grant_by_way[way] = lowest_open & {`BRU_DQ_ENTRIES{dispatch_attempt[way]}};
            dispatch_ack[way] = dispatch_attempt[way] & (|open_mask);

            // later ways see what is left
            open_mask = open_mask & ~grant_by_way[way];
        end
    end

    // ----------------------------------------------------------------------
    // way to entry crossbar

    always_comb begin
        fill_by_entry = '0;
        for (int entry = 0; entry < `BRU_DQ_ENTRIES; entry++) begin
            for (int way = 0; way < `BRU_DQ_WAYS; way++) begin
                if (grant_by_way[way][entry]) begin
                    // acked way with valid low leaves the entry empty
                    fill_by_entry[entry].valid = dispatch_valid[way];
                    fill_by_entry[entry].slot  = dispatch_slot[way];
                end
            end
        end
    end

    // no entry is claimed by two ways
    always_comb begin
        logic [`BRU_DQ_WAYS-1:0] grant_column;

        for (int entry = 0; entry < `BRU_DQ_ENTRIES; entry++) begin
            for (int way = 0; way < `BRU_DQ_WAYS; way++) begin
                grant_column[way] = grant_by_way[way][entry];
            end
            assert ($onehot0(grant_column))
                else $error("entry %0d granted to several ways: %b", entry, grant_column);
        end
    end

endmodule

`default_nettype wire

// File: source/bru_dq_entry.sv
// one dispatch queue entry with hold, shift down, fill and source wakeup
`default_nettype none
`timescale 1ns/1ps

`include "bru_dq_config.svh"

module bru_dq_entry (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  logic                                          launch,
    input  bru_dq_pkg::wb_bank_t [`PRF_BANK_COUNT-1:0]    wb_bus,
    input  bru_dq_pkg::bru_fill_t                         fill,
    input  bru_dq_pkg::bru_fill_t                         shift_in,
    output logic                                          valid,
    output bru_dq_pkg::bru_slot_t                         slot,
    output bru_dq_pkg::bru_fill_t                         shift_out
);

    // stored op, ready bits as of the last edge
    bru_dq_pkg::bru_slot_t slot_q;

    // ----------------------------------------------------------------------
    // wakeup

    // bank from the low index bits, tag compare on the rest
    function automatic logic wake_hit(
        input bru_dq_pkg::bru_src_t                       src,
        input bru_dq_pkg::wb_bank_t [`PRF_BANK_COUNT-1:0] bus
    );
        bru_dq_pkg::wb_bank_t bank;

        bank = bus[src.pr[`LOG_PRF_BANK_COUNT-1:0]];
        return bank.valid &&
            (bank.upper_pr == src.pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT]);
    endfunction

    always_comb begin
        slot         = slot_q;
        slot.a.ready = slot_q.a.ready | wake_hit(slot_q.a, wb_bus);
        slot.b.ready = slot_q.b.ready | wake_hit(slot_q.b, wb_bus);
    end

    // what the entry below takes when the queue shifts
    always_comb begin
        if (valid) begin
            shift_out.valid = 1'b1;
            shift_out.slot  = slot;
        end else begin
            // empty entry passes its dispatch straight down
            shift_out = fill;
        end
    end

    // ----------------------------------------------------------------------
    // state

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= 1'b0;
        end else if (launch) begin
            valid <= shift_in.valid;
        end else if (!valid) begin
            valid <= fill.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (launch) begin
            slot_q <= shift_in.slot;
        end else if (valid) begin
            // hold, keep any wakeup seen this cycle
            slot_q <= slot;
        end else begin
            slot_q <= fill.slot;
        end
    end

    // allocator must never target an occupied entry that stays put
    assert property (@(posedge CLK) disable iff (!nRST)
        (valid && !launch) |-> !fill.valid)
        else $error("valid fill into occupied entry");

endmodule

`default_nettype wire

// File: source/bru_dq.sv
// branch unit dispatch queue, in-order launch to the branch issue queue
`default_nettype none
`timescale 1ns/1ps

`include "bru_dq_config.svh"

module bru_dq (
    input  logic                                          CLK,
    input  logic                                          nRST,

    // dispatch
    input  logic [`BRU_DQ_WAYS-1:0]                       dispatch_attempt,
    input  logic [`BRU_DQ_WAYS-1:0]                       dispatch_valid,
    input  bru_dq_pkg::bru_slot_t [`BRU_DQ_WAYS-1:0]      dispatch_slot,
    output logic [`BRU_DQ_WAYS-1:0]                       dispatch_ack,

    // writeback bus
    input  bru_dq_pkg::wb_bank_t [`PRF_BANK_COUNT-1:0]    wb_bus,

    // issue queue enqueue
    output logic                                          iq_enq_valid,
    output bru_dq_pkg::bru_slot_t                         iq_enq_slot,
    input  logic                                          iq_enq_ready
);

    logic                                          launch;
    logic [`BRU_DQ_ENTRIES-1:0]                    valid_by_entry;
    bru_dq_pkg::bru_slot_t [`BRU_DQ_ENTRIES-1:0]   slot_by_entry;
    bru_dq_pkg::bru_fill_t [`BRU_DQ_ENTRIES-1:0]   fill_by_entry;

    // element i is the shift output of entry i
    bru_dq_pkg::bru_fill_t [`BRU_DQ_ENTRIES:0]     shift_chain;

    // ----------------------------------------------------------------------
    // allocation

    bru_dq_alloc u_alloc (
        .dispatch_attempt (dispatch_attempt),
        .dispatch_valid   (dispatch_valid),
        .dispatch_slot    (dispatch_slot),
        .entry_valid      (valid_by_entry),
        .dispatch_ack     (dispatch_ack),
        .fill_by_entry    (fill_by_entry)
    );

    // ----------------------------------------------------------------------
    // entries

    // nothing sits above the top entry
    assign shift_chain[`BRU_DQ_ENTRIES] = '0;

    for (genvar i = 0; i < `BRU_DQ_ENTRIES; i++) begin : g_entry
        bru_dq_entry u_entry (
            .CLK       (CLK),
            .nRST      (nRST),
            .launch    (launch),
            .wb_bus    (wb_bus),
            .fill      (fill_by_entry[i]),
            .shift_in  (shift_chain[i+1]),
            .valid     (valid_by_entry[i]),
            .slot      (slot_by_entry[i]),
            .shift_out (shift_chain[i])
        );
    end

    // ----------------------------------------------------------------------
    // launch from the oldest entry

    assign launch       = valid_by_entry[0] & iq_enq_ready;
    assign iq_enq_valid = launch;

    // wakeup already merged, so a same-cycle writeback goes out ready
    assign iq_enq_slot  = slot_by_entry[0];

endmodule

`default_nettype wire

// File: bench/tb_bru_dq.sv
// testbench for the branch dispatch queue driven cycle by cycle from a vector file
`default_nettype none
`timescale 1ns/1ps

`include "bru_dq_config.svh"

module tb_bru_dq;

    localparam int NUM_COLS    = 26;
    localparam int MAX_LINES   = 256;
    localparam int DRAIN_LIMIT = 16;

    logic                                       CLK;
    logic                                       nRST;
    logic [`BRU_DQ_WAYS-1:0]                    dispatch_attempt;
    logic [`BRU_DQ_WAYS-1:0]                    dispatch_valid;
    bru_dq_pkg::bru_slot_t [`BRU_DQ_WAYS-1:0]   dispatch_slot;
    logic [`BRU_DQ_WAYS-1:0]                    dispatch_ack;
    bru_dq_pkg::wb_bank_t [`PRF_BANK_COUNT-1:0] wb_bus;
    logic                                       iq_enq_valid;
    bru_dq_pkg::bru_slot_t                      iq_enq_slot;
    logic                                       iq_enq_ready;

    // columns of the current vector line
    logic [15:0] col [0:NUM_COLS-1];

    int errors;
    int checks;
    int vectors;
    int tests;
    int test_id;
    int test_errors;
    int test_vectors;

    bru_dq DUT (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_valid   (dispatch_valid),
        .dispatch_slot    (dispatch_slot),
        .dispatch_ack     (dispatch_ack),
        .wb_bus           (wb_bus),
        .iq_enq_valid     (iq_enq_valid),
        .iq_enq_slot      (iq_enq_slot),
        .iq_enq_ready     (iq_enq_ready)
    );

    always #50 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // payload and reporting helpers

    // fixed payload pattern per tag with the given sources
    function automatic bru_dq_pkg::bru_slot_t make_slot(
        input logic [7:0]               tag,
        input logic [`LOG_PR_COUNT-1:0] a_pr,
        input logic [`LOG_PR_COUNT-1:0] b_pr,
        input logic                     a_ready,
        input logic                     b_ready
    );
        bru_dq_pkg::bru_slot_t s;

        s.op.op        = tag[`BRU_OP_WIDTH-1:0] ^ tag[7:4];
        s.op.pc        = {tag, ~tag, tag ^ 8'h5a, tag + 8'h33};
        s.op.imm20     = {tag[3:0], ~tag, tag};
        s.op.dest_pr   = tag[5:0] ^ 6'h2a;
        s.op.rob_index = tag[6:0] ^ 7'h55;
        s.a.pr                  = a_pr;
        s.a.ready               = a_ready;
        s.a.unneeded_or_is_zero = tag[0];
        s.b.pr                  = b_pr;
        s.b.ready               = b_ready;
        s.b.unneeded_or_is_zero = tag[1];
        return s;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset and four-way dispatch";
            2: return "launch from a full queue";
            3: return "back-pressure fill and way-order refusal";
            4: return "launch with dispatch and shift-down";
            5: return "source wakeup while waiting and at launch";
            6: return "attempt without a valid op";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_ack(input logic [`BRU_DQ_WAYS-1:0] got,
                             input logic [`BRU_DQ_WAYS-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t dispatch_ack got %h expected %h", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t iq_enq_valid got %b expected %b", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_slot(input bru_dq_pkg::bru_slot_t got,
                              input bru_dq_pkg::bru_slot_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t iq_enq_slot got %h expected %h", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        tests++;
        $display("test %0d %s: %0d vectors, %0d errors",
            test_id, test_name(test_id), test_vectors, test_errors);
    endtask

    // ----------------------------------------------------------------------
    // one vector driven at the rising edge and checked at the falling edge

    task automatic run_vector();
        bru_dq_pkg::bru_slot_t exp_slot;

        if (int'(col[0]) != test_id) begin
            if (test_id != 0) begin
                report_test();
            end
            test_id      = int'(col[0]);
            test_errors  = 0;
            test_vectors = 0;
        end
        @(posedge CLK);
        dispatch_attempt <= col[1][`BRU_DQ_WAYS-1:0];
        dispatch_valid   <= col[2][`BRU_DQ_WAYS-1:0];
        for (int w = 0; w < `BRU_DQ_WAYS; w++) begin
            dispatch_slot[w] <= make_slot(col[3+3*w][7:0], col[4+3*w][`LOG_PR_COUNT-1:0],
                                          col[5+3*w][`LOG_PR_COUNT-1:0], 1'b0, 1'b0);
        end
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            wb_bus[b] <= col[15+b][`LOG_PR_COUNT-`LOG_PRF_BANK_COUNT:0];
        end
        iq_enq_ready <= col[19][0];
        @(negedge CLK);
        check_ack(dispatch_ack, col[20][`BRU_DQ_WAYS-1:0]);
        check_valid(iq_enq_valid, col[21][0]);
        // slot content only matters while an op goes out
        if (col[21][0]) begin
            exp_slot = make_slot(col[22][7:0], col[23][`LOG_PR_COUNT-1:0],
                                 col[24][`LOG_PR_COUNT-1:0], col[25][1], col[25][0]);
            check_slot(iq_enq_slot, exp_slot);
        end
        vectors++;
        test_vectors++;
    endtask

    // ----------------------------------------------------------------------
    // main sequence

    initial begin
        int    fd;
        int    code;
        int    n;
        int    lines;
        int    waited;
        bit    stop;
        string line;

        CLK              = 1'b0;
        nRST             <= 1'b0;
        dispatch_attempt <= '0;
        dispatch_valid   <= '0;
        dispatch_slot    <= '0;
        wb_bus           <= '0;
        iq_enq_ready     <= 1'b0;
        errors  = 0;
        checks  = 0;
        vectors = 0;
        tests   = 0;
        test_id = 0;
        lines   = 0;
        stop    = 1'b0;

        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        fd = $fopen("bench/bru_dq_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file bench/bru_dq_input.txt");
            errors++;
            stop = 1'b1;
        end
        while (!stop && lines < MAX_LINES) begin
            code = $fgets(line, fd);
            lines++;
            if (code == 0) begin
                stop = 1'b1;
            end else begin
                // comment and blank lines scan no column
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                    col[15], col[16], col[17], col[18], col[19], col[20], col[21],
                    col[22], col[23], col[24], col[25]);
                if (n == NUM_COLS) begin
                    run_vector();
                end else if (n > 0) begin
                    $display("line %0d of the vector file has %0d columns, not %0d",
                        lines, n, NUM_COLS);
                    errors++;
                    stop = 1'b1;
                end
            end
        end
        if (!stop) begin
            $display("vector file longer than %0d lines", MAX_LINES);
            errors++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (test_id != 0) begin
            report_test();
        end
        if (vectors == 0) begin
            $display("no vectors were applied");
            errors++;
        end

        // let anything left in the queue drain
        @(posedge CLK);
        dispatch_attempt <= '0;
        iq_enq_ready     <= 1'b1;
        @(negedge CLK);
        waited = 0;
        while (iq_enq_valid && waited < DRAIN_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (iq_enq_valid) begin
            $display("queue still launching after %0d cycles at the end of the run",
                DRAIN_LIMIT);
            errors++;
        end

        $display("summary: %0d tests, %0d vectors, %0d checks, %0d errors",
            tests, vectors, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/bru_dq_pkg.sv
source/bru_dq_alloc.sv
source/bru_dq_entry.sv
source/bru_dq.sv
bench/tb_bru_dq.sv

// File: run_sim.sh
#!/bin/sh
# build and run the branch dispatch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_bru_dq \
    -f src.f -Mdir obj_dir -o sim_bru_dq
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bru_dq > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

exit 0

// File: bench/bru_dq_input.txt
# test att val | way0-3: tag apr bpr | wb0-3 {valid,upper} | rdy | exp: ack iqv tag apr bpr ab
# all hex, ab is {a_ready, b_ready} of the expected launched op
1 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 0 00 00 00 0
1 f f 11 01 02 12 05 06 13 0a 0b 14 10 20 00 00 00 00 0 f 0 00 00 00 0
2 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 11 01 02 0
2 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 12 05 06 0
3 f f 21 3f 00 22 2c 1b 23 0c 0d 24 0e 0f 00 00 00 00 0 3 0 00 00 00 0
3 f f 2a 01 01 2b 02 02 2c 03 03 2d 04 04 00 00 00 00 0 0 0 00 00 00 0
4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 13 0a 0b 0
4 2 2 00 00 00 25 07 38 00 00 00 00 00 00 00 00 00 00 1 2 1 14 10 20 0
4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 21 3f 00 0
4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 22 2c 1b 0
4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 25 07 38 0
5 3 3 31 09 0e 32 16 23 00 00 00 00 00 00 00 00 00 00 0 3 0 00 00 00 0
5 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 12 14 13 0 0 0 00 00 00 0
5 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 31 09 0e 2
5 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 15 00 18 1 0 1 32 16 23 1
6 1 0 40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 1 0 00 00 00 0
6 3 1 41 11 22 42 33 04 00 00 00 00 00 00 00 00 00 00 1 3 0 00 00 00 0
6 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 1 41 11 22 0
6 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 0 00 00 00 0
